//--- Bender.yml
package:
  name: mem_pipe

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/mem_pipe_pkg.sv
      - hdl/stg_ma.sv
      - hdl/stg_mo.sv
      - hdl/dual_port_mem.sv
      - hdl/stg_wb.sv
      - hdl/mem_pipe_top.sv
  - target: simulation
    files:
      - dv/mem_pipe_chk.sv
      - dv/mem_pipe_tb.sv

//--- dv/mem_pipe_chk.sv
`timescale 1ns/1ps

module mem_pipe_chk (
    input logic                   iw_clk,
    input logic                   iw_rst,
    input mem_pipe_pkg::ma_mo_t   op,
    input logic                   addr_port,
    input mem_pipe_pkg::mem_req_t req [0:1]
);
    import mem_pipe_pkg::*;

    logic is_store;
    int   fail_cnt = 0;

    assign is_store = (op.opc == OP_ST24) || (op.opc == OP_ST48);

    // memory takes at most one write per cycle
    a_one_wr_port: assert property (@(posedge iw_clk) disable iff (iw_rst)
        !(req[0].we && req[1].we))
        else begin
            $error("both memory ports write in the same cycle");
            fail_cnt++;
        end

    // a write needs a valid store that left MA one cycle before
    a_wr_needs_valid: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (req[0].we || req[1].we) |-> $past(op.valid && is_store))
        else begin
            $error("memory write without a valid store one cycle earlier");
            fail_cnt++;
        end

    // store lands on its mp port, never on the port MA is addressing
    a_wr_on_mp: assert property (@(posedge iw_clk) disable iff (iw_rst)
        (op.valid && is_store) |=> (req[$past(op.mp)].we && !req[addr_port].we))
        else begin
            $error("store not written on the port given by mp");
            fail_cnt++;
        end

endmodule

bind mem_pipe_top mem_pipe_chk u_mem_pipe_chk (
    .iw_clk    (iw_clk),
    .iw_rst    (iw_rst),
    .op        (ma_mo),
    .addr_port (addr_port),
    .req       (mem_req)
);

//--- dv/mem_pipe_tb.sv
`timescale 1ns/1ps
`include "mem_pipe_config.svh"

module mem_pipe_tb;
    import mem_pipe_pkg::*;

    localparam int RESET_CYC = 10;

    typedef struct packed {
        logic [31:0]        due;
        mem_opc_e           opc;
        gp_idx_t            tgt;
        logic [`ADDR_W-1:0] data;
    } exp_ret_t;

    logic               iw_clk = 1'b0;
    logic               iw_rst = 1'b1;
    logic               issue_valid = 1'b0;
    issue_t             issue = '0;
    retire_t            retire;
    gp_idx_t            gp_ridx = '0;
    logic [`DATA_W-1:0] gp_rdata;
    sr_idx_t            sr_ridx = '0;
    logic [`ADDR_W-1:0] sr_rdata;

    // stimulus rows, each with the retire data it should produce
    logic               row_vld [$];
    issue_t             row_op [$];
    logic [`ADDR_W-1:0] row_exp [$];

    // reference memory and register files
    logic [`DATA_W-1:0] ref_mem [1 << `MEM_AW];
    logic [`DATA_W-1:0] gp_ref [`GP_N];
    logic [`ADDR_W-1:0] sr_ref [`SR_N];
    exp_ret_t           exp_q [$];
    int                 cyc = 0;
    int                 timeout_cyc = 1000;

    mem_pipe_top u_mem_pipe_top (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .retire      (retire),
        .gp_ridx     (gp_ridx),
        .gp_rdata    (gp_rdata),
        .sr_ridx     (sr_ridx),
        .sr_rdata    (sr_rdata)
    );

    always #10 iw_clk = ~iw_clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_val(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            abort_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, want));
        end
    endtask

    function automatic logic [`ADDR_W-1:0] rand48();
        logic [63:0] r;
        r = {$urandom, $urandom};
        return r[`ADDR_W-1:0];
    endfunction

    // append one row and advance the reference model in issue order
    task automatic add_row(input logic vld, input mem_opc_e opc, input logic [`ADDR_W-1:0] base,
                           input int off, input int tgt, input logic [`ADDR_W-1:0] wdata);
        issue_t             op;
        logic [`ADDR_W-1:0] ea;
        logic [`MEM_AW-1:0] a;
        logic [`MEM_AW-1:0] a1;
        logic [`ADDR_W-1:0] want;
        op.opc    = opc;
        op.base   = base;
        op.offset = off[`DATA_W-1:0];
        op.tgt    = gp_idx_t'(tgt);
        op.wdata  = wdata;
        ea   = base + {{(`ADDR_W-32){off[31]}}, off};
        a    = ea[`MEM_AW-1:0];
        a1   = a + 1'b1;
        want = '0;
        if (vld) begin
            case (opc)
                OP_ST24: ref_mem[a] = wdata[`DATA_W-1:0];
                OP_ST48: begin
                    ref_mem[a]  = wdata[`DATA_W-1:0];
                    ref_mem[a1] = wdata[`ADDR_W-1:`DATA_W];
                end
                OP_LD24: begin
                    want        = {{(`ADDR_W-`DATA_W){1'b0}}, ref_mem[a]};
                    gp_ref[tgt] = ref_mem[a];
                end
                OP_LD48: begin
                    want               = {ref_mem[a1], ref_mem[a]};
                    sr_ref[tgt % `SR_N] = want;
                end
                default: ;
            endcase
        end
        row_vld.push_back(vld);
        row_op.push_back(op);
        row_exp.push_back(want);
    endtask

    task automatic build_table();
        logic [`ADDR_W-1:0] hb;
        logic [`ADDR_W-1:0] w4;
        mem_opc_e           ops [4];
        hb  = rand48() & ~48'h3f;
        w4  = rand48();
        ops = '{OP_LD24, OP_LD48, OP_ST24, OP_ST48};
        add_row(1, OP_ST24, hb + 10, 0, 0, rand48());
        // idle row carries a store that must not land
        add_row(0, OP_ST24, 10, 0, 0, rand48());
        add_row(1, OP_ST48, 20, 0, 0, rand48());
        add_row(1, OP_NOP, 20, 0, 0, 0);
        add_row(1, OP_LD24, 12, -2, 1, 0);
        add_row(1, OP_LD48, 0, 20, 2, 0);
        add_row(1, OP_LD24, 20, 0, 3, 0);
        add_row(1, OP_LD24, hb + 21, 0, 4, 0);
        // wide access across the last word
        add_row(1, OP_ST48, hb + 63, 0, 0, rand48());
        add_row(1, OP_LD48, 70, -7, 0, 0);
        add_row(1, OP_LD24, 0, 0, 5, 0);
        add_row(1, OP_ST24, 30, 0, 0, rand48());
        add_row(1, OP_LD24, 30, 0, 6, 0);
        add_row(1, OP_ST48, 40, 0, 0, w4);
        add_row(1, OP_LD48, 40, 0, 3, 0);
        add_row(1, OP_ST24, 41, 0, 0, rand48());
        add_row(1, OP_LD48, 39, 1, 1, 0);
        add_row(0, OP_LD24, 0, 0, 0, 0);
        for (int i = 0; i < 16; i++) begin
            add_row(($urandom % 5) != 0, ops[$urandom % 4], rand48(),
                    int'($urandom % 201) - 100, $urandom % `GP_N, rand48());
        end
        add_row(1, OP_LD24, 63, 0, 7, 0);
    endtask

    // read every register through the two read ports
    task automatic check_regs(input logic use_ref);
        for (int i = 0; i < `GP_N; i++) begin
            @(posedge iw_clk);
            #1;
            gp_ridx = gp_idx_t'(i);
            sr_ridx = sr_idx_t'(i % `SR_N);
            @(negedge iw_clk);
            compare_val($sformatf("gp_rdata[%0d]", i), gp_rdata, use_ref ? gp_ref[i] : '0);
            compare_val($sformatf("sr_rdata[%0d]", i % `SR_N), sr_rdata,
                        use_ref ? sr_ref[i % `SR_N] : '0);
        end
    endtask

    always @(posedge iw_clk) begin
        cyc <= cyc + 1;
        if (cyc > timeout_cyc) begin
            abort_run($sformatf("timeout after %0d cycles with retires still pending", cyc));
        end
    end

    // retire must match the queue head exactly on its due cycle
    always @(negedge iw_clk) begin
        if (!iw_rst) begin
            if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                compare_val("retire.valid", retire.valid, 1);
                compare_val("retire.opc", retire.opc, exp_q[0].opc);
                compare_val("retire.tgt", retire.tgt, exp_q[0].tgt);
                compare_val("retire.data", retire.data, exp_q[0].data);
                void'(exp_q.pop_front());
            end else begin
                compare_val("retire.valid", retire.valid, 0);
            end
        end
    end

    initial begin
        exp_ret_t e;
        void'($urandom(6));
        for (int i = 0; i < (1 << `MEM_AW); i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < `GP_N; i++) begin
            gp_ref[i] = '0;
        end
        for (int i = 0; i < `SR_N; i++) begin
            sr_ref[i] = '0;
        end
        build_table();
        timeout_cyc = RESET_CYC + row_op.size() + 2 * `GP_N + 20;
        repeat (RESET_CYC) @(posedge iw_clk);
        #1;
        iw_rst = 1'b0;
        check_regs(1'b0);
        for (int i = 0; i < row_op.size(); i++) begin
            @(posedge iw_clk);
            #1;
            issue_valid = row_vld[i];
            issue       = row_op[i];
            if (row_vld[i] && row_op[i].opc != OP_NOP) begin
                e.due  = cyc + 4;
                e.opc  = row_op[i].opc;
                e.tgt  = row_op[i].tgt;
                e.data = row_exp[i];
                exp_q.push_back(e);
            end
        end
        @(posedge iw_clk);
        #1;
        issue_valid = 1'b0;
        issue       = '0;
        while (exp_q.size() != 0) begin
            @(negedge iw_clk);
        end
        check_regs(1'b1);
        if (u_mem_pipe_top.u_mem_pipe_chk.fail_cnt != 0) begin
            abort_run($sformatf("pipeline checker flagged %0d assertion failures",
                                u_mem_pipe_top.u_mem_pipe_chk.fail_cnt));
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

//--- hdl/dual_port_mem.sv
`timescale 1ns/1ps
`include "mem_pipe_config.svh"

module dual_port_mem (
    input  logic                   iw_clk,
    input  logic                   iw_rst,
    input  logic                   addr_port,
    input  logic [`ADDR_W-1:0]     addr,
    input  mem_pipe_pkg::mem_req_t mem_req [0:1],
    output logic [`ADDR_W-1:0]     rdata [0:1]
);
    import mem_pipe_pkg::*;

    localparam int DEPTH = 1 << `MEM_AW;

    logic [`DATA_W-1:0] mem [DEPTH];
    logic [`MEM_AW-1:0] a_q [0:1];
    logic [`MEM_AW-1:0] a_hi [0:1];

    // only the addressed port picks up a new address
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            a_q[0] <= '0;
            a_q[1] <= '0;
        end else begin
            a_q[addr_port] <= addr[`MEM_AW-1:0];
        end
    end

    // second word of a wide access, wraps past the last word
    always_comb begin
        a_hi[0] = a_q[0] + `MEM_AW'd1;
        a_hi[1] = a_q[1] + `MEM_AW'd1;
    end

    for (genvar p = 0; p < 2; p++) begin : g_rd
        // little-endian packing when is48 is set
        assign rdata[p] = mem_req[p].is48 ? {mem[a_hi[p]], mem[a_q[p]]}
                                          : {{(`ADDR_W-`DATA_W){1'b0}}, mem[a_q[p]]};
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (mem_req[p].we) begin
                    mem[a_q[p]] <= mem_req[p].wdata[`DATA_W-1:0];
                    if (mem_req[p].is48) begin
                        mem[a_hi[p]] <= mem_req[p].wdata[`ADDR_W-1:`DATA_W];
                    end
                end
            end
        end
    end

endmodule

//--- hdl/mem_pipe_config.svh
`ifndef MEM_PIPE_CONFIG_SVH
`define MEM_PIPE_CONFIG_SVH

// word width, also the general register width
`define DATA_W 24

// address, special register and wide data width
`define ADDR_W 48

// index bits of the 64-word data memory
`define MEM_AW 6

// general register file entries
`define GP_N 8

// special register file entries
`define SR_N 4

`endif

//--- hdl/mem_pipe_pkg.sv
`include "mem_pipe_config.svh"

package mem_pipe_pkg;

    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_LD24 = 3'd1,
        OP_LD48 = 3'd2,
        OP_ST24 = 3'd3,
        OP_ST48 = 3'd4
    } mem_opc_e;

    // register file indices
    typedef logic [$clog2(`GP_N)-1:0] gp_idx_t;
    typedef logic [$clog2(`SR_N)-1:0] sr_idx_t;

    // one micro-operation from the issue side
    typedef struct packed {
        mem_opc_e                  opc;
        logic [`ADDR_W-1:0]        base;
        logic signed [`DATA_W-1:0] offset;
        gp_idx_t                   tgt;
        logic [`ADDR_W-1:0]        wdata;
    } issue_t;

    // address stage to memory-operation stage
    typedef struct packed {
        logic               valid;
        mem_opc_e           opc;
        gp_idx_t            tgt;
        logic [`ADDR_W-1:0] wdata;
        logic               mp;
    } ma_mo_t;

    // memory-operation stage to writeback
    typedef struct packed {
        logic               valid;
        mem_opc_e           opc;
        gp_idx_t            tgt;
        logic [`ADDR_W-1:0] result;
    } mo_wb_t;

    typedef struct packed {
        logic               valid;
        mem_opc_e           opc;
        gp_idx_t            tgt;
        logic [`ADDR_W-1:0] data;
    } retire_t;

    // per-port request for one cycle
    typedef struct packed {
        logic               we;
        logic               is48;
        logic [`ADDR_W-1:0] wdata;
    } mem_req_t;

endpackage

//--- hdl/mem_pipe_top.sv
`timescale 1ns/1ps
`include "mem_pipe_config.svh"

module mem_pipe_top (
    input  logic                  iw_clk,
    input  logic                  iw_rst,
    input  logic                  issue_valid,
    input  mem_pipe_pkg::issue_t  issue,
    output mem_pipe_pkg::retire_t retire,
    input  mem_pipe_pkg::gp_idx_t gp_ridx,
    output logic [`DATA_W-1:0]    gp_rdata,
    input  mem_pipe_pkg::sr_idx_t sr_ridx,
    output logic [`ADDR_W-1:0]    sr_rdata
);
    import mem_pipe_pkg::*;

    ma_mo_t             ma_mo;
    mo_wb_t             mo_wb;
    logic               addr_port;
    logic [`ADDR_W-1:0] addr;
    mem_req_t           mem_req [0:1];
    logic [`ADDR_W-1:0] rdata [0:1];

    // address stage
    stg_ma u_stg_ma (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .addr_port   (addr_port),
        .addr        (addr),
        .ma_mo       (ma_mo)
    );

    stg_mo u_stg_mo (
        .iw_clk  (iw_clk),
        .iw_rst  (iw_rst),
        .ma_mo   (ma_mo),
        .mem_req (mem_req),
        .rdata   (rdata),
        .mo_wb   (mo_wb)
    );

    // MA and MO share it, one port each per cycle
    dual_port_mem u_dual_port_mem (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .addr_port (addr_port),
        .addr      (addr),
        .mem_req   (mem_req),
        .rdata     (rdata)
    );

    stg_wb u_stg_wb (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .mo_wb    (mo_wb),
        .gp_ridx  (gp_ridx),
        .gp_rdata (gp_rdata),
        .sr_ridx  (sr_ridx),
        .sr_rdata (sr_rdata),
        .retire   (retire)
    );

endmodule

//--- hdl/stg_ma.sv
`timescale 1ns/1ps
`include "mem_pipe_config.svh"

module stg_ma (
    input  logic                  iw_clk,
    input  logic                  iw_rst,
    input  logic                  issue_valid,
    input  mem_pipe_pkg::issue_t  issue,
    output logic                  addr_port,
    output logic [`ADDR_W-1:0]    addr,
    output mem_pipe_pkg::ma_mo_t  ma_mo
);
    import mem_pipe_pkg::*;

    logic [`ADDR_W-1:0] ea;
    logic               valid_q;
    mem_opc_e           opc_q;
    gp_idx_t            tgt_q;
    logic [`ADDR_W-1:0] wdata_q;
    logic [`ADDR_W-1:0] addr_q;
    logic               toggle_q;

    // effective address, offset is sign-extended to the full width
    always_comb begin
        ea = issue.base + {{(`ADDR_W-`DATA_W){issue.offset[`DATA_W-1]}}, issue.offset};
    end

    // port toggle runs free, MO always works on the other port
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            toggle_q <= 1'b0;
        end else begin
            toggle_q <= ~toggle_q;
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            valid_q <= 1'b0;
            opc_q   <= OP_NOP;
            tgt_q   <= '0;
            wdata_q <= '0;
            addr_q  <= '0;
        end else begin
            // a NOP still drives an address but is not qualified
            valid_q <= issue_valid && (issue.opc != OP_NOP);
            opc_q   <= issue.opc;
            tgt_q   <= issue.tgt;
            wdata_q <= issue.wdata;
            addr_q  <= ea;
        end
    end

    // address goes out on the port the toggle points at this cycle
    assign addr_port = toggle_q;
    assign addr      = addr_q;

    // mp tells MO which port got this address
    always_comb begin
        ma_mo.valid = valid_q;
        ma_mo.opc   = opc_q;
        ma_mo.tgt   = tgt_q;
        ma_mo.wdata = wdata_q;
        ma_mo.mp    = toggle_q;
    end

endmodule

//--- hdl/stg_mo.sv
`timescale 1ns/1ps
`include "mem_pipe_config.svh"

module stg_mo (
    input  logic                   iw_clk,
    input  logic                   iw_rst,
    input  mem_pipe_pkg::ma_mo_t   ma_mo,
    output mem_pipe_pkg::mem_req_t mem_req [0:1],
    input  logic [`ADDR_W-1:0]     rdata [0:1],
    output mem_pipe_pkg::mo_wb_t   mo_wb
);
    import mem_pipe_pkg::*;

    ma_mo_t             op_q;
    logic [`ADDR_W-1:0] ld_data;

    // operation enters MO on the edge the memory latches its address
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            op_q <= '0;
        end else begin
            op_q <= ma_mo;
        end
    end

    always_comb begin
        mem_req[0] = '0;
        mem_req[1] = '0;
        ld_data    = '0;
        if (op_q.valid) begin
            case (op_q.opc)
                OP_LD24: begin
                    // narrow load, high half of the port is ignored
                    ld_data = {{(`ADDR_W-`DATA_W){1'b0}}, rdata[op_q.mp][`DATA_W-1:0]};
                end
                OP_LD48: begin
                    // packing on both ports, the selected one carries the data
                    mem_req[0].is48 = 1'b1;
                    mem_req[1].is48 = 1'b1;
                    ld_data         = rdata[op_q.mp];
                end
                OP_ST24: begin
                    mem_req[op_q.mp].we    = 1'b1;
                    mem_req[op_q.mp].wdata = {{(`ADDR_W-`DATA_W){1'b0}},
                                              op_q.wdata[`DATA_W-1:0]};
                end
                OP_ST48: begin
                    // two words, low word at the address
                    mem_req[op_q.mp].we    = 1'b1;
                    mem_req[op_q.mp].is48  = 1'b1;
                    mem_req[op_q.mp].wdata = op_q.wdata;
                end
                default: begin
                end
            endcase
        end
    end

    // stores and NOPs pass a zero result
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            mo_wb <= '0;
        end else begin
            mo_wb.valid  <= op_q.valid;
            mo_wb.opc    <= op_q.opc;
            mo_wb.tgt    <= op_q.tgt;
            mo_wb.result <= ld_data;
        end
    end

endmodule

//--- hdl/stg_wb.sv
`timescale 1ns/1ps
`include "mem_pipe_config.svh"

module stg_wb (
    input  logic                  iw_clk,
    input  logic                  iw_rst,
    input  mem_pipe_pkg::mo_wb_t  mo_wb,
    input  mem_pipe_pkg::gp_idx_t gp_ridx,
    output logic [`DATA_W-1:0]    gp_rdata,
    input  mem_pipe_pkg::sr_idx_t sr_ridx,
    output logic [`ADDR_W-1:0]    sr_rdata,
    output mem_pipe_pkg::retire_t retire
);
    import mem_pipe_pkg::*;

    logic [`DATA_W-1:0] gp_rf [`GP_N];
    logic [`ADDR_W-1:0] sr_rf [`SR_N];
    sr_idx_t            sr_widx;

    // special file uses the low bits of the target
    assign sr_widx = mo_wb.tgt[$bits(sr_idx_t)-1:0];

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < `GP_N; i++) begin
                gp_rf[i] <= '0;
            end
            for (int i = 0; i < `SR_N; i++) begin
                sr_rf[i] <= '0;
            end
        end else if (mo_wb.valid) begin
            if (mo_wb.opc == OP_LD24) begin
                gp_rf[mo_wb.tgt] <= mo_wb.result[`DATA_W-1:0];
            end
            if (mo_wb.opc == OP_LD48) begin
                sr_rf[sr_widx] <= mo_wb.result;
            end
        end
    end

    assign gp_rdata = gp_rf[gp_ridx];
    assign sr_rdata = sr_rf[sr_ridx];

    // every valid op retires, stores carry a zero result from MO
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            retire <= '0;
        end else begin
            retire.valid <= mo_wb.valid;
            retire.opc   <= mo_wb.opc;
            retire.tgt   <= mo_wb.tgt;
            retire.data  <= mo_wb.result;
        end
    end

endmodule

//--- mem_pipe_top.f
+incdir+hdl
hdl/mem_pipe_pkg.sv
hdl/stg_ma.sv
hdl/stg_mo.sv
hdl/dual_port_mem.sv
hdl/stg_wb.sv
hdl/mem_pipe_top.sv
dv/mem_pipe_chk.sv
dv/mem_pipe_tb.sv
